// ==== Makefile ====
# Verilator build and run of the decode stage testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_LINE ?= ^Simulation finished: PASS$$

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_LINE)" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+hw
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_issue.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// ==== hw/id_decoder.sv ====
// Instruction decoder of the RV32I decode stage
// Turns opcode and funct fields into controls, builds immediates and the jump target
`timescale 1ns/10ps
`default_nettype none

`include "id_defs.svh"

module id_decoder
(
  input  id_pkg::instr_t     instr_i,
  input  logic               instr_valid_i,
  input  id_pkg::word_t      current_pc_i,
  input  id_pkg::word_t      rs1_rdata_i,

  output id_pkg::reg_addr_t  rs1_addr_o,
  output id_pkg::reg_addr_t  rs2_addr_o,
  output id_pkg::reg_addr_t  rd_addr_o,
  output logic               rs1_used_o,
  output logic               rs2_used_o,
  output id_pkg::alu_op_e    alu_operator_o,
  output id_pkg::op_a_sel_e  op_a_sel_o,
  output id_pkg::op_b_sel_e  op_b_sel_o,
  output id_pkg::op_c_sel_e  op_c_sel_o,
  output id_pkg::word_t      imm_b_o,
  output id_pkg::jump_kind_e jump_kind_o,
  output id_pkg::word_t      jump_target_o,
  output logic               rd_we_o,
  output logic               data_req_o,
  output logic               data_we_o,
  output logic               data_sign_ext_o,
  output id_pkg::mem_type_e  data_type_o,
  output logic               illegal_insn_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       illegal_opc;
  imm_sel_e   imm_sel;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_sb;
  word_t      imm_u;
  word_t      imm_j;

  // OP and OP-IMM share funct3, SUB only exists in register form
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                       input logic reg_form);
    case (f3)
      3'b000:  return (alt && reg_form) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b001:  return ALU_NE;
      3'b100:  return ALU_LT;
      3'b101:  return ALU_GE;
      3'b110:  return ALU_LTU;
      3'b111:  return ALU_GEU;
      default: return ALU_EQ;
    endcase
  endfunction

  // Access size from funct3[1:0]
  function automatic mem_type_e mem_size(input logic [1:0] f3_lo);
    case (f3_lo)
      2'b00:   return MEM_BYTE;
      2'b01:   return MEM_HALF;
      default: return MEM_WORD;
    endcase
  endfunction

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7_b5 = instr_i[30];

  assign rs1_addr_o = instr_i[`ID_RS1_LSB +: `ID_REG_AW];
  assign rs2_addr_o = instr_i[`ID_RS2_LSB +: `ID_REG_AW];
  assign rd_addr_o  = instr_i[`ID_RD_LSB +: `ID_REG_AW];

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // Sign extended from instr bit 31
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_j  = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb
  begin
    // Defaults describe a nop, illegal opcodes keep them
    alu_operator_o  = ALU_ADD;
    op_a_sel_o      = OPA_REG;
    op_b_sel_o      = OPB_IMM;
    op_c_sel_o      = OPC_REG;
    imm_sel         = IMM_I;
    jump_kind_o     = JK_NONE;
    rs1_used_o      = 1'b0;
    rs2_used_o      = 1'b0;
    rd_we_o         = 1'b0;
    data_req_o      = 1'b0;
    data_we_o       = 1'b0;
    data_sign_ext_o = 1'b0;
    data_type_o     = MEM_WORD;
    illegal_opc     = 1'b0;

    case (opcode)
      `ID_OPC_OP:
      begin
        rs1_used_o     = 1'b1;
        rs2_used_o     = 1'b1;
        rd_we_o        = 1'b1;
        op_b_sel_o     = OPB_REG;
        alu_operator_o = arith_op(funct3, funct7_b5, 1'b1);
      end
      `ID_OPC_OPIMM:
      begin
        rs1_used_o     = 1'b1;
        rd_we_o        = 1'b1;
        alu_operator_o = arith_op(funct3, funct7_b5, 1'b0);
      end
      // Upper immediate on B, zero or pc on A
      `ID_OPC_LUI:
      begin
        rd_we_o    = 1'b1;
        op_a_sel_o = OPA_ZERO;
        imm_sel    = IMM_U;
      end
      `ID_OPC_AUIPC:
      begin
        rd_we_o    = 1'b1;
        op_a_sel_o = OPA_PC;
        imm_sel    = IMM_U;
      end
      // Link value pc + 4 computed in EX, target rides on C
      `ID_OPC_JAL:
      begin
        rd_we_o     = 1'b1;
        op_a_sel_o  = OPA_PC;
        op_c_sel_o  = OPC_JT;
        imm_sel     = IMM_PCINCR;
        jump_kind_o = JK_JAL;
      end
      `ID_OPC_JALR:
      begin
        rs1_used_o  = 1'b1;
        rd_we_o     = 1'b1;
        op_a_sel_o  = OPA_PC;
        op_c_sel_o  = OPC_JT;
        imm_sel     = IMM_PCINCR;
        jump_kind_o = JK_JALR;
      end
      `ID_OPC_BRANCH:
      begin
        rs1_used_o     = 1'b1;
        rs2_used_o     = 1'b1;
        op_b_sel_o     = OPB_REG;
        jump_kind_o    = JK_BRANCH;
        alu_operator_o = branch_op(funct3);
      end
      `ID_OPC_LOAD:
      begin
        rs1_used_o      = 1'b1;
        rd_we_o         = 1'b1;
        data_req_o      = 1'b1;
        data_sign_ext_o = ~funct3[2];
        data_type_o     = mem_size(funct3[1:0]);
      end
      // Address on A plus B, store data on C
      `ID_OPC_STORE:
      begin
        rs1_used_o  = 1'b1;
        rs2_used_o  = 1'b1;
        data_req_o  = 1'b1;
        data_we_o   = 1'b1;
        imm_sel     = IMM_S;
        data_type_o = mem_size(funct3[1:0]);
      end
      default:
      begin
        illegal_opc = 1'b1;
      end
    endcase
  end

  assign illegal_insn_o = instr_valid_i & illegal_opc;

  // Operand B immediate
  always_comb
  begin
    case (imm_sel)
      IMM_S:      imm_b_o = imm_s;
      IMM_U:      imm_b_o = imm_u;
      IMM_PCINCR: imm_b_o = word_t'(4);
      default:    imm_b_o = imm_i;
    endcase
  end

  // JALR uses raw register file data, no forwarding on this path
  always_comb
  begin
    case (jump_kind_o)
      JK_JAL:    jump_target_o = current_pc_i + imm_j;
      JK_BRANCH: jump_target_o = current_pc_i + imm_sb;
      default:   jump_target_o = rs1_rdata_i + imm_i;
    endcase
  end

  always_comb
  begin
    assert (!(illegal_insn_o && rd_we_o))
      else $error("illegal instruction requests a register write");
  end

endmodule

`default_nettype wire

// ==== hw/id_defs.svh ====
// RV32I decode stage constants
// Word and register file sizes, major opcodes and register field positions
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Data path and register file geometry
`define ID_XLEN      32
`define ID_NUM_REGS  32
`define ID_REG_AW    5

// Major opcodes of the RV32I base set
`define ID_OPC_OP     7'h33
`define ID_OPC_OPIMM  7'h13
`define ID_OPC_LUI    7'h37
`define ID_OPC_AUIPC  7'h17
`define ID_OPC_JAL    7'h6f
`define ID_OPC_JALR   7'h67
`define ID_OPC_BRANCH 7'h63
`define ID_OPC_LOAD   7'h03
`define ID_OPC_STORE  7'h23

// Lowest bit of each register address field
`define ID_RS1_LSB 15
`define ID_RS2_LSB 20
`define ID_RD_LSB  7

`endif

// ==== hw/id_operand_issue.sv ====
// Operand issue of the decode stage
// Forwarding, operand muxes, load-use and JALR hazards, and the ID/EX register
`timescale 1ns/10ps
`default_nettype none

`include "id_defs.svh"

module id_operand_issue
(
  input  logic               clk,
  input  logic               rst_n,

  // From the decoder
  input  id_pkg::reg_addr_t  rs1_addr_i,
  input  id_pkg::reg_addr_t  rs2_addr_i,
  input  id_pkg::reg_addr_t  rd_addr_i,
  input  logic               rs1_used_i,
  input  logic               rs2_used_i,
  input  id_pkg::alu_op_e    alu_operator_i,
  input  id_pkg::op_a_sel_e  op_a_sel_i,
  input  id_pkg::op_b_sel_e  op_b_sel_i,
  input  id_pkg::op_c_sel_e  op_c_sel_i,
  input  id_pkg::word_t      imm_b_i,
  input  id_pkg::jump_kind_e jump_kind_i,
  input  id_pkg::word_t      jump_target_i,
  input  logic               rd_we_i,
  input  logic               data_req_i,
  input  logic               data_we_i,
  input  logic               data_sign_ext_i,
  input  id_pkg::mem_type_e  data_type_i,

  // Register file read data
  input  id_pkg::word_t      rs1_rdata_i,
  input  id_pkg::word_t      rs2_rdata_i,

  input  id_pkg::word_t      current_pc_i,
  input  logic               instr_valid_i,
  input  logic               ex_ready_i,

  // Forward paths
  input  logic               fw_ex_we_i,
  input  id_pkg::reg_addr_t  fw_ex_waddr_i,
  input  id_pkg::word_t      fw_ex_wdata_i,
  input  logic               wb_we_i,
  input  id_pkg::reg_addr_t  wb_waddr_i,
  input  id_pkg::word_t      wb_wdata_i,

  output logic               id_ready_o,
  output logic               id_valid_o,

  // ID/EX register
  output id_pkg::alu_op_e    alu_operator_ex_o,
  output id_pkg::word_t      alu_operand_a_ex_o,
  output id_pkg::word_t      alu_operand_b_ex_o,
  output id_pkg::word_t      alu_operand_c_ex_o,
  output id_pkg::reg_addr_t  regfile_waddr_ex_o,
  output logic               regfile_we_ex_o,
  output logic               data_req_ex_o,
  output logic               data_we_ex_o,
  output logic               data_sign_ext_ex_o,
  output id_pkg::mem_type_e  data_type_ex_o,
  output logic               branch_in_ex_o
);

  import id_pkg::*;

  fw_sel_e fw_sel_a;
  fw_sel_e fw_sel_b;
  word_t   rs1_value;
  word_t   rs2_value;
  word_t   operand_a;
  word_t   operand_b;
  word_t   operand_c;
  logic    load_in_ex;
  logic    load_stall;
  logic    jr_stall;

  // EX beats WB and x0 is never forwarded
  function automatic fw_sel_e fw_select(input reg_addr_t addr, input logic ex_we,
                                        input reg_addr_t ex_addr, input logic wb_we,
                                        input reg_addr_t wb_addr);
    if (addr == '0)
      return FW_REGFILE;
    if (ex_we && (addr == ex_addr))
      return FW_EX;
    if (wb_we && (addr == wb_addr))
      return FW_WB;
    return FW_REGFILE;
  endfunction

  function automatic word_t fw_value(input fw_sel_e sel, input word_t rf_data,
                                     input word_t ex_data, input word_t wb_data);
    case (sel)
      FW_EX:   return ex_data;
      FW_WB:   return wb_data;
      default: return rf_data;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Forwarding and operand muxes
  //////////////////////////////////////////////////

  assign fw_sel_a  = fw_select(rs1_addr_i, fw_ex_we_i, fw_ex_waddr_i, wb_we_i, wb_waddr_i);
  assign fw_sel_b  = fw_select(rs2_addr_i, fw_ex_we_i, fw_ex_waddr_i, wb_we_i, wb_waddr_i);
  assign rs1_value = fw_value(fw_sel_a, rs1_rdata_i, fw_ex_wdata_i, wb_wdata_i);
  assign rs2_value = fw_value(fw_sel_b, rs2_rdata_i, fw_ex_wdata_i, wb_wdata_i);

  always_comb
  begin
    case (op_a_sel_i)
      OPA_PC:   operand_a = current_pc_i;
      OPA_ZERO: operand_a = '0;
      default:  operand_a = rs1_value;
    endcase
  end

  assign operand_b = (op_b_sel_i == OPB_IMM) ? imm_b_i : rs2_value;
  // Store data and branch rs2, or link target
  assign operand_c = (op_c_sel_i == OPC_JT) ? jump_target_i : rs2_value;

  //////////////////////////////////////////////////
  // Hazards
  //////////////////////////////////////////////////

  // Load in ID/EX with a live destination
  assign load_in_ex = data_req_ex_o & ~data_we_ex_o & regfile_we_ex_o &
                      (regfile_waddr_ex_o != '0);
  assign load_stall = load_in_ex &
                      ((rs1_used_i & (rs1_addr_i == regfile_waddr_ex_o)) |
                       (rs2_used_i & (rs2_addr_i == regfile_waddr_ex_o)));

  // JALR target reads raw rs1 and must wait for any pending writer
  assign jr_stall = (jump_kind_i == JK_JALR) & (rs1_addr_i != '0) &
                    ((regfile_we_ex_o & (rs1_addr_i == regfile_waddr_ex_o)) |
                     (fw_ex_we_i & (rs1_addr_i == fw_ex_waddr_i)));

  assign id_ready_o = ex_ready_i & ~load_stall & ~jr_stall;
  assign id_valid_o = id_ready_o & instr_valid_i;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      alu_operator_ex_o  <= ALU_ADD;
      alu_operand_a_ex_o <= '0;
      alu_operand_b_ex_o <= '0;
      alu_operand_c_ex_o <= '0;
      regfile_waddr_ex_o <= '0;
      regfile_we_ex_o    <= 1'b0;
      data_req_ex_o      <= 1'b0;
      data_we_ex_o       <= 1'b0;
      data_sign_ext_ex_o <= 1'b0;
      data_type_ex_o     <= MEM_WORD;
      branch_in_ex_o     <= 1'b0;
    end
    else if (id_valid_o)
    begin
      alu_operator_ex_o  <= alu_operator_i;
      alu_operand_a_ex_o <= operand_a;
      alu_operand_b_ex_o <= operand_b;
      alu_operand_c_ex_o <= operand_c;
      regfile_waddr_ex_o <= rd_addr_i;
      regfile_we_ex_o    <= rd_we_i;
      data_req_ex_o      <= data_req_i;
      data_we_ex_o       <= data_we_i;
      data_sign_ext_ex_o <= data_sign_ext_i;
      data_type_ex_o     <= data_type_i;
      branch_in_ex_o     <= (jump_kind_i == JK_BRANCH);
    end
    else if (ex_ready_i)
    begin
      // Bubble into EX
      regfile_we_ex_o <= 1'b0;
      data_req_ex_o   <= 1'b0;
      branch_in_ex_o  <= 1'b0;
    end
  end

  // Load-use stall leaves a bubble behind the load
  assert property (@(posedge clk) disable iff (!rst_n)
    (load_stall && ex_ready_i) |=> (!regfile_we_ex_o && !data_req_ex_o));

  // EX back-pressure freezes the whole ID/EX register
  assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable({alu_operator_ex_o, alu_operand_a_ex_o, alu_operand_b_ex_o,
                             alu_operand_c_ex_o, regfile_waddr_ex_o, regfile_we_ex_o,
                             data_req_ex_o, data_we_ex_o, data_sign_ext_ex_o,
                             data_type_ex_o, branch_in_ex_o}));

endmodule

`default_nettype wire

// ==== hw/id_pkg.sv ====
// Types shared by the decode stage
// Word and index vectors plus the control encodings passed between blocks
`default_nettype none

`include "id_defs.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]   word_t;
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;
  typedef logic [31:0]           instr_t;

  // Arithmetic ops first, branch compares after
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic {OPB_REG, OPB_IMM} op_b_sel_e;
  // Store data or link target
  typedef enum logic {OPC_REG, OPC_JT} op_c_sel_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  typedef enum logic [1:0] {JK_NONE, JK_JAL, JK_JALR, JK_BRANCH} jump_kind_e;

  // Operand source after forwarding
  typedef enum logic [1:0] {FW_REGFILE, FW_EX, FW_WB} fw_sel_e;
  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_type_e;

endpackage

`default_nettype wire

// ==== hw/id_regfile.sv ====
// Register file of the decode stage
// 32 words, two combinational read ports, two write ports, x0 fixed at zero
`timescale 1ns/10ps
`default_nettype none

`include "id_defs.svh"

module id_regfile
(
  input  logic              clk,
  input  logic              rst_n,

  input  id_pkg::reg_addr_t raddr_a_i,
  input  id_pkg::reg_addr_t raddr_b_i,
  output id_pkg::word_t     rdata_a_o,
  output id_pkg::word_t     rdata_b_o,

  // Port A from WB, port B from the EX forward path
  input  id_pkg::reg_addr_t waddr_a_i,
  input  id_pkg::word_t     wdata_a_i,
  input  logic              we_a_i,
  input  id_pkg::reg_addr_t waddr_b_i,
  input  id_pkg::word_t     wdata_b_i,
  input  logic              we_b_i
);

  import id_pkg::*;

  word_t mem [`ID_NUM_REGS];

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `ID_NUM_REGS; i++)
        mem[i] <= '0;
    end
    else
    begin
      if (we_a_i && (waddr_a_i != '0))
        mem[waddr_a_i] <= wdata_a_i;
      // Port B last so it wins a same address write
      if (we_b_i && (waddr_b_i != '0))
        mem[waddr_b_i] <= wdata_b_i;
    end
  end

  // Entry 0 is never written after reset
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

  assert property (@(posedge clk) disable iff (!rst_n)
    ((raddr_a_i == '0) |-> (rdata_a_o == '0)) and ((raddr_b_i == '0) |-> (rdata_b_o == '0)));

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
// Decode stage top level
// Connects the decoder, the register file and the operand issue block
`timescale 1ns/10ps
`default_nettype none

`include "id_defs.svh"

module id_stage
(
  input  logic               clk,
  input  logic               rst_n,

  // From fetch
  input  logic               instr_valid_i,
  input  id_pkg::instr_t     instr_rdata_i,
  input  id_pkg::word_t      current_pc_i,

  input  logic               ex_ready_i,

  // EX forward path, also register file port B
  input  logic               fw_ex_we_i,
  input  id_pkg::reg_addr_t  fw_ex_waddr_i,
  input  id_pkg::word_t      fw_ex_wdata_i,

  // WB writeback, register file port A
  input  logic               wb_we_i,
  input  id_pkg::reg_addr_t  wb_waddr_i,
  input  id_pkg::word_t      wb_wdata_i,

  output logic               id_ready_o,
  output logic               id_valid_o,
  output logic               illegal_insn_o,
  output id_pkg::word_t      jump_target_o,

  output id_pkg::alu_op_e    alu_operator_ex_o,
  output id_pkg::word_t      alu_operand_a_ex_o,
  output id_pkg::word_t      alu_operand_b_ex_o,
  output id_pkg::word_t      alu_operand_c_ex_o,
  output id_pkg::reg_addr_t  regfile_waddr_ex_o,
  output logic               regfile_we_ex_o,
  output logic               data_req_ex_o,
  output logic               data_we_ex_o,
  output logic               data_sign_ext_ex_o,
  output id_pkg::mem_type_e  data_type_ex_o,
  output logic               branch_in_ex_o
);

  import id_pkg::*;

  // Decoded fields
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd_addr;
  logic       rs1_used;
  logic       rs2_used;
  alu_op_e    alu_operator;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  op_c_sel_e  op_c_sel;
  word_t      imm_b;
  jump_kind_e jump_kind;
  logic       rd_we;
  logic       data_req;
  logic       data_we;
  logic       data_sign_ext;
  mem_type_e  data_type;

  // Raw register file reads
  word_t      rs1_rdata;
  word_t      rs2_rdata;

  id_decoder u_decoder
  (
    .instr_i         ( instr_rdata_i  ),
    .instr_valid_i   ( instr_valid_i  ),
    .current_pc_i    ( current_pc_i   ),
    .rs1_rdata_i     ( rs1_rdata      ),
    .rs1_addr_o      ( rs1_addr       ),
    .rs2_addr_o      ( rs2_addr       ),
    .rd_addr_o       ( rd_addr        ),
    .rs1_used_o      ( rs1_used       ),
    .rs2_used_o      ( rs2_used       ),
    .alu_operator_o  ( alu_operator   ),
    .op_a_sel_o      ( op_a_sel       ),
    .op_b_sel_o      ( op_b_sel       ),
    .op_c_sel_o      ( op_c_sel       ),
    .imm_b_o         ( imm_b          ),
    .jump_kind_o     ( jump_kind      ),
    .jump_target_o   ( jump_target_o  ),
    .rd_we_o         ( rd_we          ),
    .data_req_o      ( data_req       ),
    .data_we_o       ( data_we        ),
    .data_sign_ext_o ( data_sign_ext  ),
    .data_type_o     ( data_type      ),
    .illegal_insn_o  ( illegal_insn_o )
  );

  id_regfile u_regfile
  (
    .clk       ( clk           ),
    .rst_n     ( rst_n         ),
    .raddr_a_i ( rs1_addr      ),
    .raddr_b_i ( rs2_addr      ),
    .rdata_a_o ( rs1_rdata     ),
    .rdata_b_o ( rs2_rdata     ),
    .waddr_a_i ( wb_waddr_i    ),
    .wdata_a_i ( wb_wdata_i    ),
    .we_a_i    ( wb_we_i       ),
    .waddr_b_i ( fw_ex_waddr_i ),
    .wdata_b_i ( fw_ex_wdata_i ),
    .we_b_i    ( fw_ex_we_i    )
  );

  id_operand_issue u_issue
  (
    .clk                ( clk                ),
    .rst_n              ( rst_n              ),
    .rs1_addr_i         ( rs1_addr           ),
    .rs2_addr_i         ( rs2_addr           ),
    .rd_addr_i          ( rd_addr            ),
    .rs1_used_i         ( rs1_used           ),
    .rs2_used_i         ( rs2_used           ),
    .alu_operator_i     ( alu_operator       ),
    .op_a_sel_i         ( op_a_sel           ),
    .op_b_sel_i         ( op_b_sel           ),
    .op_c_sel_i         ( op_c_sel           ),
    .imm_b_i            ( imm_b              ),
    .jump_kind_i        ( jump_kind          ),
    .jump_target_i      ( jump_target_o      ),
    .rd_we_i            ( rd_we              ),
    .data_req_i         ( data_req           ),
    .data_we_i          ( data_we            ),
    .data_sign_ext_i    ( data_sign_ext      ),
    .data_type_i        ( data_type          ),
    .rs1_rdata_i        ( rs1_rdata          ),
    .rs2_rdata_i        ( rs2_rdata          ),
    .current_pc_i       ( current_pc_i       ),
    .instr_valid_i      ( instr_valid_i      ),
    .ex_ready_i         ( ex_ready_i         ),
    .fw_ex_we_i         ( fw_ex_we_i         ),
    .fw_ex_waddr_i      ( fw_ex_waddr_i      ),
    .fw_ex_wdata_i      ( fw_ex_wdata_i      ),
    .wb_we_i            ( wb_we_i            ),
    .wb_waddr_i         ( wb_waddr_i         ),
    .wb_wdata_i         ( wb_wdata_i         ),
    .id_ready_o         ( id_ready_o         ),
    .id_valid_o         ( id_valid_o         ),
    .alu_operator_ex_o  ( alu_operator_ex_o  ),
    .alu_operand_a_ex_o ( alu_operand_a_ex_o ),
    .alu_operand_b_ex_o ( alu_operand_b_ex_o ),
    .alu_operand_c_ex_o ( alu_operand_c_ex_o ),
    .regfile_waddr_ex_o ( regfile_waddr_ex_o ),
    .regfile_we_ex_o    ( regfile_we_ex_o    ),
    .data_req_ex_o      ( data_req_ex_o      ),
    .data_we_ex_o       ( data_we_ex_o       ),
    .data_sign_ext_ex_o ( data_sign_ext_ex_o ),
    .data_type_ex_o     ( data_type_ex_o     ),
    .branch_in_ex_o     ( branch_in_ex_o     )
  );

endmodule

`default_nettype wire

// ==== verif/id_testdata.txt ====
// in:  ctl(valid ready fw_we wb_we) instr pc fw_addr fw_data wb_addr wb_data
// out: flags(rdy vld ill we req dwe sext br) jump_target alu dtype rd op_a op_b op_c
4 00000013 0 00 0 00 0 80 0 0 2 00 0 0 0
5 00000013 0 00 0 01 1000 80 0 0 2 00 0 0 0
5 00000013 0 00 0 02 20 80 0 0 2 00 0 0 0
6 00000013 0 03 fffffff0 00 0 80 0 0 2 00 0 0 0
c 00208233 100 00 0 00 0 c0 1002 0 2 00 0 0 0
f 403082b3 104 03 7 01 500 d0 1403 0 2 04 1000 20 20
f ff010313 108 02 aaaa 02 bbbb d0 10 1 2 05 500 7 7
c 123453b7 10c 00 0 00 0 d0 123 0 2 06 aaaa fffffff0 0
c fffff417 110 00 0 00 0 d0 ffffffff 0 2 07 0 12345000 7
c fe30ac23 114 00 0 00 0 d0 4e3 0 2 08 110 fffff000 0
c 00c11483 118 00 0 00 0 cc aab6 0 2 18 500 fffffff8 7
c 00148533 11c 00 0 00 0 1a 1 0 1 09 aaaa c 0
d 00148533 11c 00 0 09 1234 c2 1 0 1 09 aaaa c 0
c 020000ef 120 00 0 00 0 d0 140 0 2 0a 1234 500 500
c 008082e7 140 00 0 00 0 10 508 0 2 01 120 4 140
e 008082e7 140 01 124 00 0 00 508 0 2 01 120 4 140
c 008082e7 140 00 0 00 0 c0 12c 0 2 01 120 4 140
c fe9198e3 12c 00 0 00 0 d0 11c 0 2 05 140 4 12c
8 0034c5b3 130 00 0 00 0 01 1237 b 2 11 7 1234 1234
8 0034c5b3 130 00 0 00 0 01 1237 b 2 11 7 1234 1234
c 0034c5b3 130 00 0 00 0 c1 1237 b 2 11 7 1234 1234
c 0040800b 134 00 0 00 0 f0 128 5 2 0b 1234 7 7
4 00000013 0 00 0 00 0 80 0 0 2 00 124 4 0
4 0040800b 134 00 0 00 0 80 128 0 2 00 124 4 0
f 00000633 138 00 dead 00 beef c0 0 0 2 00 124 4 0
c 7ff00693 13c 00 0 00 0 d0 7ff 0 2 0c 0 0 0
c 0034c703 140 00 0 00 0 d0 1237 0 2 0d 0 7ff 0
c 00e12023 144 00 0 00 0 18 aab8 0 0 0e 1234 3 7
e 00e12023 144 0e a5 00 0 c0 aab8 0 0 0e 1234 3 7
4 00000013 0 00 0 00 0 8c 0 0 2 00 aaaa 0 a5
0 00000013 0 00 0 00 0 04 0 0 2 00 aaaa 0 a5
c 000707b3 148 00 0 00 0 c4 a5 0 2 00 aaaa 0 a5
4 00000013 0 00 0 00 0 90 0 0 2 0f a5 0 0
4 00000013 0 00 0 00 0 80 0 0 2 0f a5 0 0

// ==== verif/tb_id_stage.sv ====
// Testbench for the RV32I decode stage
// Replays one vector per cycle from a data file and checks every output before each edge
`timescale 1ns/10ps
`default_nettype none

`include "id_defs.svh"

module tb_id_stage;

  localparam int CLK_PERIOD   = 10;
  localparam int DRIVE_DELAY  = 1;
  localparam int SAMPLE_LEAD  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int SLACK_CYCLES = 20;

  // Vector memory with NUM_FIELDS words per line
  localparam int NUM_FIELDS = 15;
  localparam int ADDR_W     = 10;
  localparam int MAX_WORDS  = 1 << ADDR_W;
  localparam int MAX_LINES  = MAX_WORDS / NUM_FIELDS;

  // Field order within a line
  localparam int F_CTL   = 0;
  localparam int F_INSTR = 1;
  localparam int F_PC    = 2;
  localparam int F_FWA   = 3;
  localparam int F_FWD   = 4;
  localparam int F_WBA   = 5;
  localparam int F_WBD   = 6;
  localparam int F_FLAGS = 7;
  localparam int F_JT    = 8;
  localparam int F_ALU   = 9;
  localparam int F_DTYPE = 10;
  localparam int F_WA    = 11;
  localparam int F_OPA   = 12;
  localparam int F_OPB   = 13;
  localparam int F_OPC   = 14;

  logic                  clk;
  logic                  rst_n;

  // DUT inputs
  logic                  instr_valid;
  logic [31:0]           instr_rdata;
  logic [`ID_XLEN-1:0]   current_pc;
  logic                  ex_ready;
  logic                  fw_ex_we;
  logic [`ID_REG_AW-1:0] fw_ex_waddr;
  logic [`ID_XLEN-1:0]   fw_ex_wdata;
  logic                  wb_we;
  logic [`ID_REG_AW-1:0] wb_waddr;
  logic [`ID_XLEN-1:0]   wb_wdata;

  // DUT outputs
  logic                  id_ready;
  logic                  id_valid;
  logic                  illegal_insn;
  logic [`ID_XLEN-1:0]   jump_target;
  logic [3:0]            alu_operator_ex;
  logic [`ID_XLEN-1:0]   alu_operand_a_ex;
  logic [`ID_XLEN-1:0]   alu_operand_b_ex;
  logic [`ID_XLEN-1:0]   alu_operand_c_ex;
  logic [`ID_REG_AW-1:0] regfile_waddr_ex;
  logic                  regfile_we_ex;
  logic                  data_req_ex;
  logic                  data_we_ex;
  logic                  data_sign_ext_ex;
  logic [1:0]            data_type_ex;
  logic                  branch_in_ex;

  logic [31:0] stim [MAX_WORDS];
  int          num_lines;
  int          cycle_count = 0;
  int          cycle_limit = MAX_LINES + SLACK_CYCLES;

  id_stage u_id_stage
  (
    .clk                ( clk              ),
    .rst_n              ( rst_n            ),
    .instr_valid_i      ( instr_valid      ),
    .instr_rdata_i      ( instr_rdata      ),
    .current_pc_i       ( current_pc       ),
    .ex_ready_i         ( ex_ready         ),
    .fw_ex_we_i         ( fw_ex_we         ),
    .fw_ex_waddr_i      ( fw_ex_waddr      ),
    .fw_ex_wdata_i      ( fw_ex_wdata      ),
    .wb_we_i            ( wb_we            ),
    .wb_waddr_i         ( wb_waddr         ),
    .wb_wdata_i         ( wb_wdata         ),
    .id_ready_o         ( id_ready         ),
    .id_valid_o         ( id_valid         ),
    .illegal_insn_o     ( illegal_insn     ),
    .jump_target_o      ( jump_target      ),
    .alu_operator_ex_o  ( alu_operator_ex  ),
    .alu_operand_a_ex_o ( alu_operand_a_ex ),
    .alu_operand_b_ex_o ( alu_operand_b_ex ),
    .alu_operand_c_ex_o ( alu_operand_c_ex ),
    .regfile_waddr_ex_o ( regfile_waddr_ex ),
    .regfile_we_ex_o    ( regfile_we_ex    ),
    .data_req_ex_o      ( data_req_ex      ),
    .data_we_ex_o       ( data_we_ex       ),
    .data_sign_ext_ex_o ( data_sign_ext_ex ),
    .data_type_ex_o     ( data_type_ex     ),
    .branch_in_ex_o     ( branch_in_ex     )
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] vector_field(input int line, input int field);
    return stim[ADDR_W'(line * NUM_FIELDS + field)];
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Ctl nibble is valid, ready, EX write, WB write from msb down
  task automatic drive_inputs(input int line);
    logic [31:0] ctl;
    logic [31:0] fw_addr_word;
    logic [31:0] wb_addr_word;
    ctl          = vector_field(line, F_CTL);
    fw_addr_word = vector_field(line, F_FWA);
    wb_addr_word = vector_field(line, F_WBA);
    instr_valid  = ctl[3];
    ex_ready     = ctl[2];
    fw_ex_we     = ctl[1];
    wb_we        = ctl[0];
    instr_rdata  = vector_field(line, F_INSTR);
    current_pc   = vector_field(line, F_PC);
    fw_ex_waddr  = fw_addr_word[`ID_REG_AW-1:0];
    fw_ex_wdata  = vector_field(line, F_FWD);
    wb_waddr     = wb_addr_word[`ID_REG_AW-1:0];
    wb_wdata     = vector_field(line, F_WBD);
  endtask

  // Flag byte holds ready, valid, illegal, we, req, data we, sign ext, branch
  task automatic compare_outputs(input int line);
    logic [31:0] flags;
    flags = vector_field(line, F_FLAGS);
    check_value("id_ready_o", 32'(id_ready), 32'(flags[7]));
    check_value("id_valid_o", 32'(id_valid), 32'(flags[6]));
    check_value("illegal_insn_o", 32'(illegal_insn), 32'(flags[5]));
    check_value("regfile_we_ex_o", 32'(regfile_we_ex), 32'(flags[4]));
    check_value("data_req_ex_o", 32'(data_req_ex), 32'(flags[3]));
    check_value("data_we_ex_o", 32'(data_we_ex), 32'(flags[2]));
    check_value("data_sign_ext_ex_o", 32'(data_sign_ext_ex), 32'(flags[1]));
    check_value("branch_in_ex_o", 32'(branch_in_ex), 32'(flags[0]));
    check_value("jump_target_o", jump_target, vector_field(line, F_JT));
    check_value("alu_operator_ex_o", 32'(alu_operator_ex), vector_field(line, F_ALU));
    check_value("data_type_ex_o", 32'(data_type_ex), vector_field(line, F_DTYPE));
    check_value("regfile_waddr_ex_o", 32'(regfile_waddr_ex), vector_field(line, F_WA));
    check_value("alu_operand_a_ex_o", alu_operand_a_ex, vector_field(line, F_OPA));
    check_value("alu_operand_b_ex_o", alu_operand_b_ex, vector_field(line, F_OPB));
    check_value("alu_operand_c_ex_o", alu_operand_c_ex, vector_field(line, F_OPC));
  endtask

  //////////////////////////////////////////////////
  // Timeout
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr_rdata = 32'h0000_0013;
    current_pc  = '0;
    ex_ready    = 1'b1;
    fw_ex_we    = 1'b0;
    fw_ex_waddr = '0;
    fw_ex_wdata = '0;
    wb_we       = 1'b0;
    wb_waddr    = '0;
    wb_wdata    = '0;

    // Unused words read back above 4'hf, which marks the end of the vectors
    for (int a = 0; a < MAX_WORDS; a++)
      stim[ADDR_W'(a)] = {16'hffff, 16'(a)};
    $readmemh("verif/id_testdata.txt", stim);

    num_lines = 0;
    while ((num_lines < MAX_LINES) && (vector_field(num_lines, F_CTL) <= 32'hf))
      num_lines++;
    if (num_lines == 0)
    begin
      $display("no test vectors were loaded from the data file");
      abort_run();
    end
    cycle_limit = num_lines + SLACK_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    // Drive just after the edge and sample just before the next one
    for (int line = 0; line < num_lines; line++)
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
      drive_inputs(line);
      #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
      compare_outputs(line);
    end

    $display("%0d cycles checked", num_lines);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
